//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f vlog.f --top-module pio_tb -o pio_sim \
  > build.log 2>&1 || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/pio_sim > sim.log 2>&1 || { cat sim.log; echo "Simulation exited with error"; exit 1; }

cat sim.log
grep -q "TESTBENCH FAILED" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log || { echo "No pass message in log"; exit 1; }
exit 0

//--- source/pio.sv
`include "pio_macros.svh"

module pio
  import pio_host_pkg::*;
(
  input  logic                               clk,
  input  logic                               reset,
  input  logic [$clog2(`PIO_NUM_SM)-1:0]     mindex,
  input  logic [31:0]                        din,
  input  logic [$clog2(`PIO_IMEM_DEPTH)-1:0] index,
  input  logic [3:0]                         action,
  input  logic [31:0]                        gpio_in,
  output logic [31:0]                        dout,
  output logic [31:0]                        gpio_out,
  output logic [31:0]                        gpio_dir,
  output logic [`PIO_NUM_SM-1:0]             full,
  output logic [`PIO_NUM_SM-1:0]             empty
);

  logic [15:0]           imem [`PIO_IMEM_DEPTH];  // Shared program memory
  pio_sm_cfg_t           cfg [`PIO_NUM_SM];
  logic [31:0]           init_pins [`PIO_NUM_SM];
  logic [31:0]           init_dirs [`PIO_NUM_SM];
  logic [`PIO_NUM_SM-1:0] en;
  logic [`PIO_NUM_SM-1:0] restart;
  logic [`PIO_NUM_SM-1:0] imm_q;
  logic [`PIO_NUM_SM-1:0] push_q;
  logic [`PIO_NUM_SM-1:0] pull_q;
  logic [31:0]           push_word;
  logic [15:0]           imm_word;

  logic [31:0]           rx_head [`PIO_NUM_SM];
  logic [4:0]            pc [`PIO_NUM_SM];
  logic [31:0]           sm_pins [`PIO_NUM_SM];
  logic [31:0]           sm_dirs [`PIO_NUM_SM];
  pio_action_e           act;

  assign act = pio_action_e'(action);

  always_ff @(posedge clk) begin
    if (act == INSTR) imem[index] <= din[15:0];
  end

  // Payloads captured with the action
  always_ff @(posedge clk) begin
    if (act == PUSH) push_word <= din;
    if (act == IMM) imm_word <= din[15:0];
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      en      <= '0;
      restart <= '0;
      imm_q   <= '0;
      push_q  <= '0;
      pull_q  <= '0;
      dout    <= '0;
      for (int i = 0; i < `PIO_NUM_SM; i++) begin
        cfg[i]       <= '0;
        init_pins[i] <= '0;
        init_dirs[i] <= '0;
      end
    end else begin
      restart <= '0;
      imm_q   <= '0;
      push_q  <= '0;
      pull_q  <= '0;
      case (act)
        PEND: begin
          cfg[mindex].pend        <= din[4:0];
          cfg[mindex].pstart      <= din[9:5];
          cfg[mindex].wrap_target <= din[14:10];
        end
        PULL: begin
          pull_q[mindex] <= 1'b1;  // Pop lands one cycle after dout
          dout           <= rx_head[mindex];
        end
        PUSH: push_q[mindex] <= 1'b1;
        GRPS: begin
          cfg[mindex].pins_out_base  <= din[4:0];
          cfg[mindex].pins_set_base  <= din[9:5];
          cfg[mindex].pins_in_base   <= din[19:15];
          cfg[mindex].pins_out_count <= din[25:20];
          cfg[mindex].pins_set_count <= din[28:26];
        end
        EN: begin
          en      <= din[`PIO_NUM_SM-1:0];
          restart <= din[`PIO_NUM_SM+3:4];
        end
        DIV:   cfg[mindex].div <= din[23:8];  // Fraction bits 7:0 ignored
        IMM:   imm_q[mindex] <= 1'b1;
        SHIFT: begin
          cfg[mindex].in_shift_dir  <= din[18];
          cfg[mindex].out_shift_dir <= din[19];
          cfg[mindex].isr_threshold <= din[24:20];
          cfg[mindex].osr_threshold <= din[29:25];
        end
        IPINS: init_pins[mindex] <= din;
        IDIRS: init_dirs[mindex] <= din;
        default: ;
      endcase
    end
  end

  for (genvar j = 0; j < `PIO_NUM_SM; j++) begin : mach
    pio_fifo_if tx_if ();
    pio_fifo_if rx_if ();

    assign tx_if.push      = push_q[j];
    assign tx_if.push_data = push_word;
    assign full[j]         = tx_if.full;
    assign rx_if.pull      = pull_q[j];
    assign rx_head[j]      = rx_if.pull_data;
    assign empty[j]        = rx_if.empty;

    pio_fifo #(.DEPTH(`PIO_FIFO_DEPTH)) u_tx_fifo (
      .clk   (clk),
      .reset (reset),
      .f     (tx_if.fifo)
    );

    pio_fifo #(.DEPTH(`PIO_FIFO_DEPTH)) u_rx_fifo (
      .clk   (clk),
      .reset (reset),
      .f     (rx_if.fifo)
    );

    pio_machine u_machine (
      .clk       (clk),
      .reset     (reset),
      .en        (en[j]),
      .restart   (restart[j]),
      .cfg       (cfg[j]),
      .instr     (imem[cfg[j].pstart + pc[j]]),  // Relative pc, wraps in 5 bits
      .imm       (imm_q[j]),
      .imm_instr (imm_word),
      .gpio_in   (gpio_in),
      .init_pins (init_pins[j]),
      .init_dirs (init_dirs[j]),
      .pc        (pc[j]),
      .pins_out  (sm_pins[j]),
      .pins_dir  (sm_dirs[j]),
      .tx        (tx_if.consumer),
      .rx        (rx_if.producer)
    );
  end

  // Each machine drives only where its directions are set
  always_comb begin
    gpio_out = '0;
    gpio_dir = '0;
    for (int i = 0; i < `PIO_NUM_SM; i++) begin
      gpio_out = gpio_out | (sm_pins[i] & sm_dirs[i]);
      gpio_dir = gpio_dir | sm_dirs[i];
    end
  end

endmodule

//--- source/pio_fifo.sv
module pio_fifo #(
  parameter int DEPTH = 4
) (
  input  logic     clk,
  input  logic     reset,
  pio_fifo_if.fifo f
);

  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  logic [31:0]   mem [DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          do_push;
  logic          do_pull;

  assign do_push     = f.push && !f.full;
  assign do_pull     = f.pull && !f.empty;
  assign f.full      = (count == CW'(DEPTH));
  assign f.empty     = (count == '0);
  assign f.pull_data = mem[rd_ptr];  // Head word shows without a pull

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= f.push_data;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pull) rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({do_push, do_pull})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither
      endcase
    end
  end

endmodule

//--- source/pio_fifo_if.sv
interface pio_fifo_if;
  logic        push;       // Ignored while full
  logic [31:0] push_data;
  logic        full;
  logic        pull;       // Ignored while empty
  logic [31:0] pull_data;  // Always the head word
  logic        empty;

  modport producer (
    output push, output push_data,
    input  full
  );

  modport consumer (
    output pull,
    input  pull_data, input empty
  );

  modport fifo (
    input  push, input push_data, input pull,
    output full, output pull_data, output empty
  );
endinterface

//--- source/pio_host_pkg.sv
package pio_host_pkg;

  // Host action codes, sampled on the action port
  typedef enum logic [3:0] {
    NONE  = 4'd0,
    INSTR = 4'd1,   // Write one instruction word
    PEND  = 4'd2,   // Program end, start and wrap target
    PULL  = 4'd3,   // Read RX head into dout
    PUSH  = 4'd4,   // Write din into TX FIFO
    GRPS  = 4'd5,   // Pin groups
    EN    = 4'd6,   // Enable and restart masks
    DIV   = 4'd7,   // Clock divider
    IMM   = 4'd9,   // Immediate instruction
    SHIFT = 4'd10,  // Shift directions and thresholds
    IPINS = 4'd11,  // Initial pin values
    IDIRS = 4'd12   // Initial pin directions
  } pio_action_e;

  // One machine's configuration
  typedef struct packed {
    logic [4:0]  pstart;          // Program offset in shared memory
    logic [4:0]  pend;            // Last pc before wrap
    logic [4:0]  wrap_target;
    logic [15:0] div;             // Integer divider, 0 and 1 run every cycle
    logic [4:0]  pins_in_base;
    logic [4:0]  pins_out_base;
    logic [4:0]  pins_set_base;
    logic [5:0]  pins_out_count;
    logic [2:0]  pins_set_count;
    logic        in_shift_dir;    // 1 shifts right
    logic        out_shift_dir;   // 1 shifts right
    logic [4:0]  isr_threshold;   // 0 means 32
    logic [4:0]  osr_threshold;   // 0 means 32
  } pio_sm_cfg_t;

endpackage

//--- source/pio_isa_pkg.sv
package pio_isa_pkg;

  // Instruction word fields
  localparam int OP_MSB    = 15;
  localparam int OP_LSB    = 13;
  localparam int DELAY_MSB = 12;
  localparam int DELAY_LSB = 8;
  localparam int ARG_MSB   = 7;   // Condition, source or destination
  localparam int ARG_LSB   = 5;
  localparam int LOW_MSB   = 4;   // Count, address or value
  localparam int LOW_LSB   = 0;

  // PUSH and PULL flag bits
  localparam int PP_PULL_BIT  = 7;
  localparam int PP_IF_BIT    = 6;  // IfFull or IfEmpty
  localparam int PP_BLOCK_BIT = 5;

  typedef enum logic [2:0] {
    OP_JMP      = 3'd0,
    OP_IN       = 3'd2,
    OP_OUT      = 3'd3,
    OP_PUSHPULL = 3'd4,
    OP_SET      = 3'd7
  } pio_op_e;

  typedef enum logic [2:0] {
    JMP_ALWAYS   = 3'd0,
    JMP_NOT_X    = 3'd1,
    JMP_X_DEC    = 3'd2,
    JMP_NOT_Y    = 3'd3,
    JMP_Y_DEC    = 3'd4,
    JMP_NOT_OSRE = 3'd7
  } pio_jmp_cond_e;

  typedef enum logic [2:0] {SRC_PINS = 3'd0, SRC_X = 3'd1, SRC_Y = 3'd2, SRC_NULL = 3'd3} pio_src_e;

  typedef enum logic [2:0] {
    DST_PINS = 3'd0, DST_X = 3'd1, DST_Y = 3'd2, DST_NULL = 3'd3, DST_PINDIRS = 3'd4
  } pio_dst_e;

endpackage

//--- source/pio_machine.sv
module pio_machine
  import pio_host_pkg::*;
  import pio_isa_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  logic         en,
  input  logic         restart,
  input  pio_sm_cfg_t  cfg,
  input  logic [15:0]  instr,
  input  logic         imm,
  input  logic [15:0]  imm_instr,
  input  logic [31:0]  gpio_in,
  input  logic [31:0]  init_pins,
  input  logic [31:0]  init_dirs,
  output logic [4:0]   pc,
  output logic [31:0]  pins_out,
  output logic [31:0]  pins_dir,
  pio_fifo_if.consumer tx,
  pio_fifo_if.producer rx
);

  function automatic logic [31:0] rotl(input logic [31:0] v, input logic [4:0] n);
    logic [63:0] t;
    t = {v, v} << n;
    return t[63:32];
  endfunction

  function automatic logic [31:0] rotr(input logic [31:0] v, input logic [4:0] n);
    logic [63:0] t;
    t = {v, v} >> n;
    return t[31:0];
  endfunction

  // n low ones, n up to 32
  function automatic logic [31:0] lsb_mask(input logic [5:0] n);
    return ~(32'hffff_ffff << n);
  endfunction

  // Replace count bits at base, wrapping past bit 31
  function automatic logic [31:0] write_field(input logic [31:0] old, input logic [31:0] data,
                                              input logic [4:0] base, input logic [5:0] count);
    logic [31:0] m;
    m = rotl(lsb_mask(count), base);
    return (old & ~m) | (rotl(data, base) & m);
  endfunction

  function automatic logic [5:0] sat_add(input logic [5:0] a, input logic [5:0] b);
    logic [6:0] s;
    s = a + b;
    return (s > 7'd32) ? 6'd32 : s[5:0];
  endfunction

  function automatic logic [5:0] thr(input logic [4:0] t);
    return (t == 5'd0) ? 6'd32 : {1'b0, t};
  endfunction

  logic [15:0]   div_cnt;
  logic [4:0]    delay_cnt;
  logic          imm_pend;
  logic [15:0]   imm_word;
  logic [31:0]   x;
  logic [31:0]   y;
  logic [31:0]   isr;
  logic [31:0]   osr;
  logic [5:0]    isr_cnt;
  logic [5:0]    osr_cnt;

  logic          tick;
  logic          exec_imm;
  logic          exec;
  logic          stall;
  logic [15:0]   cur;
  pio_op_e       op;
  pio_jmp_cond_e cond;
  pio_src_e      src;
  pio_dst_e      dst;
  logic [4:0]    delay;
  logic [4:0]    low;
  logic [5:0]    nbits;
  logic          pp_pull;
  logic          pp_skip;
  logic          pp_wait;
  logic          jmp_take;
  logic [4:0]    pc_seq;
  logic [31:0]   out_data;
  logic [31:0]   osr_shifted;
  logic [31:0]   in_val;
  logic [31:0]   isr_shifted;

  assign tick     = en && (cfg.div <= 16'd1 || div_cnt == cfg.div - 16'd1);
  assign exec_imm = imm_pend && (en ? tick : 1'b1);  // Runs even while disabled
  assign exec     = exec_imm || (tick && !imm_pend && delay_cnt == 5'd0);

  assign cur   = imm_pend ? imm_word : instr;
  assign op    = pio_op_e'(cur[OP_MSB:OP_LSB]);
  assign cond  = pio_jmp_cond_e'(cur[ARG_MSB:ARG_LSB]);
  assign src   = pio_src_e'(cur[ARG_MSB:ARG_LSB]);
  assign dst   = pio_dst_e'(cur[ARG_MSB:ARG_LSB]);
  assign delay = cur[DELAY_MSB:DELAY_LSB];
  assign low   = cur[LOW_MSB:LOW_LSB];
  assign nbits = (low == 5'd0) ? 6'd32 : {1'b0, low};

  // PUSH and PULL handling
  assign pp_pull = cur[PP_PULL_BIT];
  assign pp_skip = cur[PP_IF_BIT] && (pp_pull ? (osr_cnt < thr(cfg.osr_threshold))
                                              : (isr_cnt < thr(cfg.isr_threshold)));
  assign pp_wait = !pp_skip && cur[PP_BLOCK_BIT] && (pp_pull ? tx.empty : rx.full);
  assign stall   = (op == OP_PUSHPULL) && pp_wait;

  assign tx.pull      = exec && op == OP_PUSHPULL && pp_pull && !pp_skip && !tx.empty;
  assign rx.push      = exec && op == OP_PUSHPULL && !pp_pull && !pp_skip && !rx.full;
  assign rx.push_data = isr;

  assign pc_seq = (pc == cfg.pend) ? cfg.wrap_target : pc + 5'd1;

  always_comb begin
    case (cond)
      JMP_ALWAYS:   jmp_take = 1'b1;
      JMP_NOT_X:    jmp_take = (x == '0);
      JMP_X_DEC:    jmp_take = (x != '0);  // Tested before the decrement
      JMP_NOT_Y:    jmp_take = (y == '0);
      JMP_Y_DEC:    jmp_take = (y != '0);
      JMP_NOT_OSRE: jmp_take = (osr_cnt < thr(cfg.osr_threshold));
      default:      jmp_take = 1'b0;
    endcase
  end

  // OUT takes the low bits when shifting right, else the high bits
  assign out_data    = cfg.out_shift_dir ? (osr & lsb_mask(nbits)) : (osr >> (6'd32 - nbits));
  assign osr_shifted = cfg.out_shift_dir ? (osr >> nbits) : (osr << nbits);

  always_comb begin
    case (src)
      SRC_PINS: in_val = rotr(gpio_in, cfg.pins_in_base);
      SRC_X:    in_val = x;
      SRC_Y:    in_val = y;
      default:  in_val = '0;
    endcase
    in_val = in_val & lsb_mask(nbits);
  end

  assign isr_shifted = cfg.in_shift_dir ? ((isr >> nbits) | (in_val << (6'd32 - nbits)))
                                        : ((isr << nbits) | in_val);

  always_ff @(posedge clk) begin
    if (reset || restart) div_cnt <= '0;
    else if (en) div_cnt <= tick ? 16'd0 : div_cnt + 16'd1;
  end

  // Immediate waits here for the next tick
  always_ff @(posedge clk) begin
    if (reset) imm_pend <= 1'b0;
    else if (imm) imm_pend <= 1'b1;
    else if (exec_imm && !stall) imm_pend <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (imm) imm_word <= imm_instr;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc        <= '0;
      x         <= '0;
      y         <= '0;
      isr       <= '0;
      osr       <= '0;
      isr_cnt   <= '0;
      osr_cnt   <= '0;
      delay_cnt <= '0;
      pins_out  <= '0;
      pins_dir  <= '0;
    end else if (restart) begin
      pc        <= '0;
      x         <= '0;
      y         <= '0;
      isr       <= '0;
      osr       <= '0;
      isr_cnt   <= '0;
      osr_cnt   <= '0;
      delay_cnt <= '0;
      pins_out  <= init_pins;
      pins_dir  <= init_dirs;
    end else begin
      if (tick && !imm_pend && delay_cnt != 5'd0) delay_cnt <= delay_cnt - 5'd1;
      if (exec && !stall) begin
        if (!exec_imm) delay_cnt <= delay;  // Immediates skip the delay
        if (op == OP_JMP && jmp_take) pc <= low;
        else if (!exec_imm) pc <= pc_seq;
        case (op)
          OP_JMP: begin
            if (cond == JMP_X_DEC) x <= x - 32'd1;
            if (cond == JMP_Y_DEC) y <= y - 32'd1;
          end
          OP_IN: begin
            isr     <= isr_shifted;
            isr_cnt <= sat_add(isr_cnt, nbits);
          end
          OP_OUT: begin
            osr     <= osr_shifted;
            osr_cnt <= sat_add(osr_cnt, nbits);
            case (dst)
              DST_PINS: begin
                pins_out <= write_field(pins_out, out_data, cfg.pins_out_base,
                                        cfg.pins_out_count);
              end
              DST_X:    x <= out_data;
              DST_Y:    y <= out_data;
              DST_PINDIRS: begin
                pins_dir <= write_field(pins_dir, out_data, cfg.pins_out_base,
                                        cfg.pins_out_count);
              end
              default: ;  // NULL discards
            endcase
          end
          OP_PUSHPULL: begin
            if (!pp_skip && pp_pull) begin
              osr     <= tx.empty ? x : tx.pull_data;  // Empty non-blocking pull takes x
              osr_cnt <= '0;
            end else if (!pp_skip) begin
              isr     <= '0;  // Word dropped if RX was full
              isr_cnt <= '0;
            end
          end
          OP_SET: begin
            case (dst)
              DST_PINS: begin
                pins_out <= write_field(pins_out, {27'd0, low}, cfg.pins_set_base,
                                        {3'd0, cfg.pins_set_count});
              end
              DST_X:    x <= {27'd0, low};
              DST_Y:    y <= {27'd0, low};
              DST_PINDIRS: begin
                pins_dir <= write_field(pins_dir, {27'd0, low}, cfg.pins_set_base,
                                        {3'd0, cfg.pins_set_count});
              end
              default: ;
            endcase
          end
          default: ;
        endcase
      end
    end
  end

endmodule

//--- source/pio_macros.svh
`ifndef PIO_MACROS_SVH
`define PIO_MACROS_SVH

// State machines sharing the instruction memory
`define PIO_NUM_SM 4

// Shared instruction words
`define PIO_IMEM_DEPTH 32

// Words per TX or RX FIFO
`define PIO_FIFO_DEPTH 4

`endif

//--- tb/pio_tb.sv
`include "pio_macros.svh"

module pio_tb
  import pio_host_pkg::*;
();

  // Instruction words used by the test programs
  localparam logic [15:0] I_PULL_BLK  = 16'h80a0;
  localparam logic [15:0] I_PUSH_BLK  = 16'h8020;
  localparam logic [15:0] I_OUT_X32   = 16'h6020;
  localparam logic [15:0] I_IN_X32    = 16'h4020;
  localparam logic [15:0] I_OUT_PINS8 = 16'h6008;
  localparam logic [15:0] I_JMP_XDEC  = 16'h0040;  // Address in low 5 bits
  localparam logic [15:0] I_SET_PINS  = 16'he000;
  localparam logic [15:0] I_SET_DIRS  = 16'he080;

  localparam int TOTAL_WORDS     = 16 + 2 + 4 + 4 + 16;  // Words sent through machines
  localparam int CYCLES_PER_WORD = 64;    // Loop at div 5 plus host handshakes
  localparam int SETUP_CYCLES    = 600;   // Config writes, program loads and idles
  localparam int TIMEOUT_CYCLES  = TOTAL_WORDS * CYCLES_PER_WORD + SETUP_CYCLES;

  logic                   clk;
  logic                   reset;
  logic [1:0]             mindex;
  logic [31:0]            din;
  logic [4:0]             index;
  logic [3:0]             action;
  logic [31:0]            gpio_in;
  logic [31:0]            dout;
  logic [31:0]            gpio_out;
  logic [31:0]            gpio_dir;
  logic [`PIO_NUM_SM-1:0] full;
  logic [`PIO_NUM_SM-1:0] empty;

  logic [31:0] seed = 32'h952c2355;
  logic [31:0] exp_q [`PIO_NUM_SM][$];  // Expected RX words per machine
  int          cycles = 0;
  int          checks = 0;
  int          mismatches = 0;
  int          test_errs = 0;
  int          tests_run = 0;
  int          tests_failed = 0;

  pio dut (
    .clk      (clk),
    .reset    (reset),
    .mindex   (mindex),
    .din      (din),
    .index    (index),
    .action   (action),
    .gpio_in  (gpio_in),
    .dout     (dout),
    .gpio_out (gpio_out),
    .gpio_dir (gpio_dir),
    .full     (full),
    .empty    (empty)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the DUT never answered", TIMEOUT_CYCLES);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] v;
    v = s ^ (s << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  function automatic logic [31:0] next_rand();
    seed = xorshift(seed);
    return seed;
  endfunction

  function automatic logic [31:0] rotl32(input logic [31:0] v, input logic [4:0] n);
    if (n == 5'd0) return v;
    return (v << n) | (v >> (6'd32 - n));
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
    checks++;
    if (got !== want) begin
      $display("FAILED %s: got %h, expected %h", name, got, want);
      mismatches++;
      test_errs++;
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errs == 0) begin
      $display("Test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: %0d mismatches", tests_run, name, test_errs);
    end
    test_errs = 0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  // One host action, held for one cycle
  task automatic host_write(input pio_action_e a, input int m, input logic [4:0] idx,
                            input logic [31:0] d);
    @(posedge clk);
    action <= a;
    mindex <= 2'(m);
    index  <= idx;
    din    <= d;
    @(posedge clk);
    action <= NONE;
  endtask

  task automatic push_word(input int m, input logic [31:0] w);
    host_write(PUSH, m, 5'd0, w);
    exp_q[m].push_back(w);
  endtask

  task automatic wait_rx(input int m);
    do begin
      @(negedge clk);
    end while (empty[m]);
  endtask

  task automatic pull_check(input int m);
    logic [31:0] want;
    wait_rx(m);
    host_write(PULL, m, 5'd0, 32'd0);
    @(negedge clk);  // dout holds the head from here
    if (exp_q[m].size() == 0) begin
      $display("Machine %0d returned a word that was never expected", m);
      mismatches++;
      test_errs++;
    end else begin
      want = exp_q[m].pop_front();
      check($sformatf("dout[sm%0d]", m), dout, want);
    end
  endtask

  task automatic load_loopback(input logic [4:0] base);
    host_write(INSTR, 0, base, {16'd0, I_PULL_BLK});
    host_write(INSTR, 0, base + 5'd1, {16'd0, I_OUT_X32});
    host_write(INSTR, 0, base + 5'd2, {16'd0, I_IN_X32});
    host_write(INSTR, 0, base + 5'd3, {16'd0, I_PUSH_BLK});
  endtask

  initial begin
    logic [31:0] w;
    logic [4:0]  base;
    logic        dir;
    logic [4:0]  val;
    logic [7:0]  byte_exp;
    logic [31:0] mask;
    reset   = 1'b1;
    mindex  = '0;
    din     = '0;
    index   = '0;
    action  = NONE;
    gpio_in = '0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;

    load_loopback(5'd0);
    host_write(PEND, 0, 5'd0, 32'd3);   // pend 3, start 0, wrap 0
    host_write(EN, 0, 5'd0, 32'h11);    // Run and restart machine 0
    for (int g = 0; g < 4; g++) begin
      for (int k = 0; k < `PIO_FIFO_DEPTH; k++) begin
        push_word(0, next_rand());
      end
      for (int k = 0; k < `PIO_FIFO_DEPTH; k++) begin
        pull_check(0);
      end
    end
    finish_test("loopback");

    for (int t = 0; t < 3; t++) begin
      w    = next_rand();
      base = w[4:0];
      val  = w[12:8];
      host_write(GRPS, 2, 5'd0, (32'd5 << 26) | (32'(base) << 5));  // Set count 5
      host_write(IMM, 2, 5'd0, {16'd0, I_SET_DIRS | 16'd31});
      idle_cycles(4);
      host_write(IMM, 2, 5'd0, {16'd0, I_SET_PINS | {11'd0, val}});
      idle_cycles(4);
      @(negedge clk);
      mask = rotl32(32'h1f, base);
      check("gpio_out", gpio_out & mask, rotl32({27'd0, val}, base));
      check("gpio_dir", gpio_dir & mask, mask);
    end
    finish_test("set pins");

    host_write(INSTR, 0, 5'd4, {16'd0, I_PULL_BLK});
    host_write(INSTR, 0, 5'd5, {16'd0, I_OUT_PINS8});
    host_write(INSTR, 0, 5'd6, {16'd0, I_PUSH_BLK});  // Empty ISR marks the end
    host_write(PEND, 1, 5'd0, 32'd2 | (32'd4 << 5));
    for (int t = 0; t < 2; t++) begin
      w    = next_rand();
      base = w[4:0];
      dir  = w[5];
      mask = rotl32(32'hff, base);
      host_write(GRPS, 1, 5'd0, (32'd8 << 20) | 32'(base));
      host_write(SHIFT, 1, 5'd0, 32'(dir) << 19);
      host_write(IDIRS, 1, 5'd0, mask);
      host_write(EN, 0, 5'd0, 32'h63);  // Run 0 and 1, restart 1 and 2
      w = next_rand();
      host_write(PUSH, 1, 5'd0, w);
      exp_q[1].push_back(32'd0);
      pull_check(1);
      byte_exp = dir ? w[7:0] : w[31:24];
      check("gpio_out", gpio_out & mask, rotl32({24'd0, byte_exp}, base));
      check("gpio_dir", gpio_dir & mask, mask);
    end
    finish_test("out pins");

    host_write(INSTR, 0, 5'd8, {16'd0, I_PULL_BLK});
    host_write(INSTR, 0, 5'd9, {16'd0, I_OUT_X32});
    host_write(INSTR, 0, 5'd10, {16'd0, I_JMP_XDEC | 16'd2});  // Spins on itself
    host_write(INSTR, 0, 5'd11, {16'd0, I_IN_X32});
    host_write(INSTR, 0, 5'd12, {16'd0, I_PUSH_BLK});
    host_write(PEND, 1, 5'd0, 32'd4 | (32'd8 << 5));
    host_write(EN, 0, 5'd0, 32'h23);
    for (int t = 0; t < 4; t++) begin
      w = next_rand();
      host_write(PUSH, 1, 5'd0, {28'd0, w[3:0]});
      exp_q[1].push_back(32'hffff_ffff);  // x wraps below zero on exit
      pull_check(1);
    end
    finish_test("jump loop");

    host_write(EN, 0, 5'd0, 32'h00);
    for (int k = 0; k < `PIO_FIFO_DEPTH; k++) begin
      push_word(0, next_rand());
    end
    idle_cycles(2);
    @(negedge clk);
    check("full[0]", {31'd0, full[0]}, 32'd1);
    check("empty[0]", {31'd0, empty[0]}, 32'd1);
    host_write(PUSH, 0, 5'd0, next_rand());  // Dropped
    idle_cycles(2);
    @(negedge clk);
    check("full[0]", {31'd0, full[0]}, 32'd1);
    check("empty[0]", {31'd0, empty[0]}, 32'd1);
    host_write(EN, 0, 5'd0, 32'h01);
    for (int k = 0; k < `PIO_FIFO_DEPTH; k++) begin
      pull_check(0);
    end
    idle_cycles(30);
    @(negedge clk);
    check("empty[0]", {31'd0, empty[0]}, 32'd1);
    check("full[0]", {31'd0, full[0]}, 32'd0);
    finish_test("fifo flags");

    load_loopback(5'd16);
    host_write(PEND, 3, 5'd0, 32'd3 | (32'd16 << 5));
    host_write(DIV, 0, 5'd0, 32'd3 << 8);
    host_write(DIV, 3, 5'd0, 32'd5 << 8);
    host_write(EN, 0, 5'd0, 32'h99);  // Run and restart 0 and 3
    for (int r = 0; r < 2; r++) begin
      for (int k = 0; k < `PIO_FIFO_DEPTH; k++) begin
        push_word(0, next_rand());
        push_word(3, next_rand());
      end
      for (int k = 0; k < `PIO_FIFO_DEPTH; k++) begin
        pull_check(0);
        pull_check(3);
      end
    end
    finish_test("two machines");

    $display("%0d tests, %0d failed, %0d checks, %0d mismatches",
             tests_run, tests_failed, checks, mismatches);
    if (mismatches == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+source
source/pio_host_pkg.sv
source/pio_isa_pkg.sv
source/pio_fifo_if.sv
source/pio_fifo.sv
source/pio_machine.sv
source/pio.sv
tb/pio_tb.sv
